/* all.f */
disc_ctrl_pkg.sv
mcu_reg_if.sv
sram_fifo.sv
sram_write_ctrl.sv
index_timer.sv
disc_ctrl_top.sv
tb_disc_ctrl.sv

/* disc_ctrl_pkg.sv */
`default_nettype none

package disc_ctrl_pkg;

	//////////////////////////////
	// Widths and types
	//////////////////////////////

	typedef logic [7:0]  byte_t;          // Bus, FIFO and SRAM data
	typedef logic [7:0]  reg_addr_t;      // Latched register address
	typedef logic [18:0] sram_addr_t;     // 512K x 8 SRAM
	typedef logic [15:0] index_count_t;   // Index period in 10us ticks
	typedef logic [15:0] tick_div_t;      // 10us prescaler count

	// Memory write controller
	typedef enum logic [2:0] {
		MWC_IDLE      = 3'd0,   // Wait for FIFO data
		MWC_OE_OFF    = 3'd1,   // Release SRAM outputs, pop FIFO
		MWC_WRITE     = 3'd2,   // WE low
		MWC_WRITE_END = 3'd3,   // WE high again
		MWC_INC_ADDR  = 3'd4    // Next address
	} mwc_state_t;

	//////////////////////////////
	// Identity
	//////////////////////////////

	localparam logic [15:0] MCO_TYPE    = 16'hDD55;   // Microcode type
	localparam logic [15:0] MCO_VERSION = 16'h001F;   // Microcode version

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam reg_addr_t REG_SRAM_ADDR_LOW   = 8'h00;
	localparam reg_addr_t REG_SRAM_ADDR_HIGH  = 8'h01;
	localparam reg_addr_t REG_SRAM_ADDR_UPPER = 8'h02;   // Bits 18..16 only
	localparam reg_addr_t REG_SRAM_DATA       = 8'h03;   // Write queues, read autoincrements
	localparam reg_addr_t REG_MCO_TYPE_L      = 8'h04;
	localparam reg_addr_t REG_MCO_TYPE_H      = 8'h05;
	localparam reg_addr_t REG_MCO_VER_L       = 8'h06;
	localparam reg_addr_t REG_MCO_VER_H       = 8'h07;
	localparam reg_addr_t REG_STATUS          = 8'h0E;   // Any write clears overflow
	localparam reg_addr_t REG_SCRATCH         = 8'h30;
	localparam reg_addr_t REG_SCRATCH_INV     = 8'h31;
	localparam reg_addr_t REG_FIXED_55        = 8'h32;
	localparam reg_addr_t REG_FIXED_AA        = 8'h33;
	localparam reg_addr_t REG_INDEX_HIGH      = 8'h40;   // Read first, freezes low byte
	localparam reg_addr_t REG_INDEX_LOW       = 8'h41;

	// Status register bits
	localparam int STAT_BUSY     = 0;   // Write queue still draining
	localparam int STAT_OVERFLOW = 1;   // Sticky, byte dropped on full FIFO

	//////////////////////////////
	// FIFO and timing
	//////////////////////////////

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = 4;    // log2 of FIFO_DEPTH

	// 100 MHz master clock
	localparam tick_div_t TICK_10US_DIV = 16'd1000;

endpackage

`default_nettype wire

/* disc_ctrl_top.sv */
`default_nettype none

module disc_ctrl_top import disc_ctrl_pkg::*; (
	input  wire logic       CLK_MASTER,    // 100 MHz
	input  wire logic       rst_n,
	input  wire byte_t      mcu_pmd_in,
	input  wire logic       mcu_pmall,
	input  wire logic       mcu_pmrd,
	input  wire logic       mcu_pmwr,
	input  wire logic       fd_index_in,
	input  wire byte_t      sram_dq_in,
	output wire byte_t      mcu_pmd_out,
	output wire sram_addr_t sram_a,
	output wire byte_t      sram_dq_out,   // Board enables it while OE is off
	output wire logic       sram_we_n,
	output wire logic       sram_oe_n,
	output wire logic       sram_ce_n
);

	wire logic         fifo_push;
	wire byte_t        fifo_wdata;
	wire logic         fifo_pop;
	wire byte_t        fifo_rdata;
	wire logic         fifo_empty;
	wire logic         fifo_full;
	wire logic         addr_load_low;
	wire logic         addr_load_high;
	wire logic         addr_load_upper;
	wire byte_t        load_data;
	wire logic         rd_inc;
	wire logic         busy;
	wire index_count_t index_period;

	// SRAM stays selected for the fastest access
	assign sram_ce_n = 1'b0;

	//////////////////////////////
	// Host side
	//////////////////////////////

	mcu_reg_if i_mcu_reg_if (
		.CLK_MASTER      (CLK_MASTER),
		.rst_n           (rst_n),
		.mcu_pmd_in      (mcu_pmd_in),
		.mcu_pmall       (mcu_pmall),
		.mcu_pmrd        (mcu_pmrd),
		.mcu_pmwr        (mcu_pmwr),
		.sram_dq_in      (sram_dq_in),
		.sram_a          (sram_a),
		.busy            (busy),
		.fifo_full       (fifo_full),
		.index_period    (index_period),
		.mcu_pmd_out     (mcu_pmd_out),
		.fifo_push       (fifo_push),
		.fifo_wdata      (fifo_wdata),
		.addr_load_low   (addr_load_low),
		.addr_load_high  (addr_load_high),
		.addr_load_upper (addr_load_upper),
		.load_data       (load_data),
		.rd_inc          (rd_inc)
	);

	index_timer i_index_timer (
		.CLK_MASTER   (CLK_MASTER),
		.rst_n        (rst_n),
		.fd_index_in  (fd_index_in),
		.index_period (index_period)
	);

	//////////////////////////////
	// Write queue and SRAM side
	//////////////////////////////

	sram_fifo i_sram_fifo (
		.CLK_MASTER (CLK_MASTER),
		.rst_n      (rst_n),
		.push       (fifo_push),
		.wdata      (fifo_wdata),
		.pop        (fifo_pop),
		.rdata      (fifo_rdata),
		.empty      (fifo_empty),
		.full       (fifo_full)
	);

	sram_write_ctrl i_sram_write_ctrl (
		.CLK_MASTER      (CLK_MASTER),
		.rst_n           (rst_n),
		.fifo_empty      (fifo_empty),
		.fifo_rdata      (fifo_rdata),
		.addr_load_low   (addr_load_low),
		.addr_load_high  (addr_load_high),
		.addr_load_upper (addr_load_upper),
		.load_data       (load_data),
		.rd_inc          (rd_inc),
		.fifo_pop        (fifo_pop),
		.sram_a          (sram_a),
		.sram_dq_out     (sram_dq_out),
		.sram_we_n       (sram_we_n),
		.sram_oe_n       (sram_oe_n),
		.busy            (busy)
	);

endmodule

`default_nettype wire

/* index_timer.sv */
`default_nettype none

module index_timer import disc_ctrl_pkg::*; (
	input  wire logic    CLK_MASTER,
	input  wire logic    rst_n,
	input  wire logic    fd_index_in,
	output index_count_t index_period
);

	logic [2:0]   index_sync;   // Stage 0 meets the raw pin
	logic         index_rise;
	tick_div_t    div_q;
	logic         tick_10us;
	index_count_t period_cnt;   // Ticks since last index

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			index_sync <= '0;
		end else begin
			index_sync <= {index_sync[1:0], fd_index_in};
		end
	end

	assign index_rise = index_sync[1] & ~index_sync[2];

	//////////////////////////////
	// 10us prescaler
	//////////////////////////////

	assign tick_10us = (div_q == (TICK_10US_DIV - 1'b1));

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n || tick_10us) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	// Latch and restart on each index, hold at max for a stopped disc
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			period_cnt   <= '0;
			index_period <= '0;
		end else if (index_rise) begin
			index_period <= period_cnt;
			period_cnt   <= '0;
		end else if (tick_10us && (period_cnt != '1)) begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* mcu_reg_if.sv */
`default_nettype none

module mcu_reg_if import disc_ctrl_pkg::*; (
	input  wire logic         CLK_MASTER,
	input  wire logic         rst_n,
	input  wire byte_t        mcu_pmd_in,
	input  wire logic         mcu_pmall,
	input  wire logic         mcu_pmrd,
	input  wire logic         mcu_pmwr,
	input  wire byte_t        sram_dq_in,
	input  wire sram_addr_t   sram_a,
	input  wire logic         busy,
	input  wire logic         fifo_full,
	input  wire index_count_t index_period,
	output byte_t             mcu_pmd_out,
	output logic              fifo_push,
	output byte_t             fifo_wdata,
	output logic              addr_load_low,
	output logic              addr_load_high,
	output logic              addr_load_upper,
	output byte_t             load_data,
	output logic              rd_inc
);

	reg_addr_t addr_q;        // Latched register address
	logic      wr_sync;       // PMWR sampled
	logic      wr_sync_d;
	logic      rd_sync;       // PMRD sampled
	logic      rd_sync_d;
	logic      wr_pulse;      // One cycle per host write
	logic      rd_rise;
	logic      rd_fall;
	logic      overflow_q;    // Sticky FIFO overrun
	byte_t     scratch_q;
	byte_t     sram_dq_lat;   // SRAM byte held for the host
	byte_t     index_low_q;   // Frozen low byte of period
	byte_t     status_byte;

	//////////////////////////////
	// Address latch and strobes
	//////////////////////////////

	// Follows the bus for as long as PMALL is high
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			addr_q <= '0;
		end else if (mcu_pmall) begin
			addr_q <= mcu_pmd_in;
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			wr_sync   <= 1'b0;
			wr_sync_d <= 1'b0;
			rd_sync   <= 1'b0;
			rd_sync_d <= 1'b0;
		end else begin
			wr_sync   <= mcu_pmwr;
			wr_sync_d <= wr_sync;
			rd_sync   <= mcu_pmrd;
			rd_sync_d <= rd_sync;
		end
	end

	assign wr_pulse = wr_sync & ~wr_sync_d;   // Second cycle of the write
	assign rd_rise  = rd_sync & ~rd_sync_d;
	assign rd_fall  = ~rd_sync & rd_sync_d;   // One cycle after PMRD drops

	//////////////////////////////
	// Write decode
	//////////////////////////////

	// SRAM data goes into the write queue
	assign fifo_push  = wr_pulse && (addr_q == REG_SRAM_DATA);
	assign fifo_wdata = mcu_pmd_in;

	// Address counter lives in the write controller
	assign addr_load_low   = wr_pulse && (addr_q == REG_SRAM_ADDR_LOW);
	assign addr_load_high  = wr_pulse && (addr_q == REG_SRAM_ADDR_HIGH);
	assign addr_load_upper = wr_pulse && (addr_q == REG_SRAM_ADDR_UPPER);
	assign load_data       = mcu_pmd_in;

	// Advance after each completed data read
	assign rd_inc = rd_fall && (addr_q == REG_SRAM_DATA);

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			overflow_q <= 1'b0;
		end else if (fifo_push && fifo_full) begin
			overflow_q <= 1'b1;   // Byte lost
		end else if (wr_pulse && (addr_q == REG_STATUS)) begin
			overflow_q <= 1'b0;
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if (wr_pulse && (addr_q == REG_SCRATCH)) begin
			scratch_q <= mcu_pmd_in;
		end
		// Track SRAM until the read starts, then hold still
		if (!rd_sync && (addr_q == REG_SRAM_DATA)) begin
			sram_dq_lat <= sram_dq_in;
		end
		// Low byte matches the high byte being read
		if (rd_rise && (addr_q == REG_INDEX_HIGH)) begin
			index_low_q <= index_period[7:0];
		end
	end

	//////////////////////////////
	// Readback mux
	//////////////////////////////

	always_comb begin
		status_byte                = '0;
		status_byte[STAT_BUSY]     = busy;
		status_byte[STAT_OVERFLOW] = overflow_q;
	end

	always_comb begin
		case (addr_q)
			REG_SRAM_ADDR_LOW:   mcu_pmd_out = sram_a[7:0];
			REG_SRAM_ADDR_HIGH:  mcu_pmd_out = sram_a[15:8];
			REG_SRAM_ADDR_UPPER: mcu_pmd_out = {5'b00000, sram_a[18:16]};
			REG_SRAM_DATA:       mcu_pmd_out = sram_dq_lat;
			REG_MCO_TYPE_L:      mcu_pmd_out = MCO_TYPE[7:0];
			REG_MCO_TYPE_H:      mcu_pmd_out = MCO_TYPE[15:8];
			REG_MCO_VER_L:       mcu_pmd_out = MCO_VERSION[7:0];
			REG_MCO_VER_H:       mcu_pmd_out = MCO_VERSION[15:8];
			REG_STATUS:          mcu_pmd_out = status_byte;
			REG_SCRATCH:         mcu_pmd_out = scratch_q;
			REG_SCRATCH_INV:     mcu_pmd_out = ~scratch_q;   // Bus bit test
			REG_FIXED_55:        mcu_pmd_out = 8'h55;
			REG_FIXED_AA:        mcu_pmd_out = 8'hAA;
			REG_INDEX_HIGH:      mcu_pmd_out = index_period[15:8];
			REG_INDEX_LOW:       mcu_pmd_out = index_low_q;
			default:             mcu_pmd_out = '0;
		endcase
	end

	// A data byte and an address byte never share one write pulse
	a_push_not_load: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		fifo_push |-> !(addr_load_low || addr_load_high || addr_load_upper));

endmodule

`default_nettype wire

/* sram_fifo.sv */
`default_nettype none

module sram_fifo import disc_ctrl_pkg::*; (
	input  wire logic  CLK_MASTER,
	input  wire logic  rst_n,
	input  wire logic  push,
	input  wire byte_t wdata,
	input  wire logic  pop,
	output byte_t      rdata,
	output logic       empty,
	output logic       full
);

	byte_t                 mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count_q;   // 0 .. FIFO_DEPTH
	logic                  do_push;
	logic                  do_pop;

	assign empty = (count_q == '0);
	assign full  = count_q[FIFO_PTR_W];   // Depth is a power of two

	assign do_push = push && !full;   // Push on full is dropped
	assign do_pop  = pop && !empty;

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge CLK_MASTER) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
		if (do_pop) begin
			rdata <= mem[rd_ptr];   // Valid the cycle after pop
		end
	end

	//////////////////////////////
	// Pointers and count
	//////////////////////////////

	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;   // Natural wrap
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop && !do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// Consumer only pops a non-empty queue
	a_no_pop_empty: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		pop |-> !empty);

	// A push into a full queue leaves nothing behind
	a_no_push_full: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		(push && full) |=> (wr_ptr == $past(wr_ptr)));

endmodule

`default_nettype wire

/* sram_write_ctrl.sv */
`default_nettype none

module sram_write_ctrl import disc_ctrl_pkg::*; (
	input  wire logic  CLK_MASTER,
	input  wire logic  rst_n,
	input  wire logic  fifo_empty,
	input  wire byte_t fifo_rdata,
	input  wire logic  addr_load_low,
	input  wire logic  addr_load_high,
	input  wire logic  addr_load_upper,
	input  wire byte_t load_data,
	input  wire logic  rd_inc,
	output logic       fifo_pop,
	output sram_addr_t sram_a,
	output byte_t      sram_dq_out,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic       busy
);

	mwc_state_t state_q;
	mwc_state_t state_d;

	//////////////////////////////
	// Write sequencer
	//////////////////////////////

	// Five cycles per byte
	always_comb begin
		state_d = state_q;
		case (state_q)
			MWC_IDLE: begin
				if (!fifo_empty) begin
					state_d = MWC_OE_OFF;
				end
			end
			MWC_OE_OFF: begin
				state_d = MWC_WRITE;
			end
			MWC_WRITE: begin
				state_d = MWC_WRITE_END;
			end
			MWC_WRITE_END: begin
				state_d = MWC_INC_ADDR;
			end
			MWC_INC_ADDR: begin
				state_d = MWC_IDLE;   // Recheck FIFO
			end
			default: begin
				state_d = MWC_IDLE;
			end
		endcase
	end

	// Strobes registered from the next state, no decode glitches on the pins
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			state_q   <= MWC_IDLE;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;   // SRAM drives the bus when idle
		end else begin
			state_q   <= state_d;
			sram_we_n <= (state_d != MWC_WRITE);
			sram_oe_n <= (state_d != MWC_IDLE);
		end
	end

	assign fifo_pop    = (state_q == MWC_OE_OFF);   // Byte ready in WRITE
	assign sram_dq_out = fifo_rdata;                // Held until next pop
	assign busy        = (state_q != MWC_IDLE) || !fifo_empty;

	//////////////////////////////
	// Address counter
	//////////////////////////////

	// Host loads win over increments
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			sram_a <= '0;
		end else if (addr_load_low) begin
			sram_a[7:0] <= load_data;
		end else if (addr_load_high) begin
			sram_a[15:8] <= load_data;
		end else if (addr_load_upper) begin
			sram_a[18:16] <= load_data[2:0];   // Upper bits masked
		end else if ((state_q == MWC_INC_ADDR) || rd_inc) begin
			sram_a <= sram_a + 1'b1;   // Wraps at 19 bits
		end
	end

	// WE only drops once OE has been off for a full cycle
	a_we_needs_oe_off: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!sram_we_n |-> (sram_oe_n && $past(sram_oe_n)));

endmodule

`default_nettype wire

/* tb_disc_ctrl.sv */
`default_nettype none

module tb_disc_ctrl import disc_ctrl_pkg::*; ();

	localparam logic [1:0] K_WRITE     = 2'd0;   // Write data column
	localparam logic [1:0] K_READ      = 2'd1;   // Compare with exp column
	localparam logic [1:0] K_WRITE_RND = 2'd2;   // Write next LFSR byte
	localparam logic [1:0] K_READ_RND  = 2'd3;   // Expect last LFSR byte xor data column

	localparam int         N_STEPS   = 16;
	localparam int         OVF_BYTES = 100;        // Four cycles each against a five cycle drain
	localparam sram_addr_t WR_START  = 19'h00140;
	// Table ops, about 80 other bus ops, both index gaps, the burst, margin
	localparam int LIMIT = (N_STEPS + 80) * 10 + (5 + 12) * TICK_10US_DIV
		+ OVF_BYTES * 4 + 2000;

	typedef struct packed {
		logic [1:0] kind;
		reg_addr_t  addr;
		byte_t      data;
		byte_t      exp;
	} step_t;

	logic       CLK_MASTER;
	logic       rst_n;
	byte_t      mcu_pmd_in;
	logic       mcu_pmall;
	logic       mcu_pmrd;
	logic       mcu_pmwr;
	logic       fd_index_in;
	wire byte_t      sram_dq_in;
	wire byte_t      mcu_pmd_out;
	wire sram_addr_t sram_a;
	wire byte_t      sram_dq_out;
	wire logic       sram_we_n;
	wire logic       sram_oe_n;
	wire logic       sram_ce_n;

	step_t       steps [N_STEPS];
	byte_t       sram_mem [512];      // Low 9 address bits only
	byte_t       wr_bytes [8];        // Bytes queued in the write test
	byte_t       rnd_q;
	logic [15:0] lfsr_q = 16'd45;
	int          cycle_cnt = 0;
	int          n_checks = 0;
	int          n_errors = 0;

	disc_ctrl_top i_dut (
		.CLK_MASTER  (CLK_MASTER),
		.rst_n       (rst_n),
		.mcu_pmd_in  (mcu_pmd_in),
		.mcu_pmall   (mcu_pmall),
		.mcu_pmrd    (mcu_pmrd),
		.mcu_pmwr    (mcu_pmwr),
		.fd_index_in (fd_index_in),
		.sram_dq_in  (sram_dq_in),
		.mcu_pmd_out (mcu_pmd_out),
		.sram_a      (sram_a),
		.sram_dq_out (sram_dq_out),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n),
		.sram_ce_n   (sram_ce_n)
	);

	initial CLK_MASTER = 1'b0;
	always #5 CLK_MASTER = ~CLK_MASTER;

	//////////////////////////////
	// SRAM model and run limit
	//////////////////////////////

	initial begin
		for (int i = 0; i < 512; i++) begin
			sram_mem[i] = byte_t'(i ^ (i >> 3));   // Bit 8 folds into bit 5
		end
	end

	// Chip must be selected for a write to land
	always @(posedge sram_we_n) begin
		if (rst_n && !sram_ce_n) begin
			sram_mem[sram_a[8:0]] <= sram_dq_out;   // Latch on WE rising
		end
	end

	assign sram_dq_in = (sram_oe_n || sram_ce_n) ? 8'h00 : sram_mem[sram_a[8:0]];

	always @(posedge CLK_MASTER) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("Timeout, run went past %0d cycles", LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois form with taps 16 14 13 11
	endfunction

	task automatic draw_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			b[i]   = lfsr_q[0];   // One step per bit
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic bus_write(input reg_addr_t a, input byte_t d);
		@(posedge CLK_MASTER);
		mcu_pmd_in <= a;
		mcu_pmall  <= 1'b1;
		@(posedge CLK_MASTER);
		mcu_pmall  <= 1'b0;
		mcu_pmd_in <= d;
		mcu_pmwr   <= 1'b1;
		repeat (4) @(posedge CLK_MASTER);
		mcu_pmwr <= 1'b0;
		@(posedge CLK_MASTER);   // Gap
	endtask

	task automatic bus_read(input reg_addr_t a, output byte_t d);
		@(posedge CLK_MASTER);
		mcu_pmd_in <= a;
		mcu_pmall  <= 1'b1;
		@(posedge CLK_MASTER);
		mcu_pmall <= 1'b0;
		mcu_pmrd  <= 1'b1;
		repeat (3) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);
		d = mcu_pmd_out;   // Sampled mid-cycle on a settled bus
		@(posedge CLK_MASTER);
		mcu_pmrd <= 1'b0;
		repeat (2) @(posedge CLK_MASTER);   // Lets the autoincrement land
	endtask

	task automatic load_sram_addr(input sram_addr_t a);
		bus_write(REG_SRAM_ADDR_LOW, a[7:0]);
		bus_write(REG_SRAM_ADDR_HIGH, a[15:8]);
		bus_write(REG_SRAM_ADDR_UPPER, {5'b00000, a[18:16]});
	endtask

	task automatic read_sram_addr(output sram_addr_t a);
		byte_t lo;
		byte_t hi;
		byte_t up;
		bus_read(REG_SRAM_ADDR_LOW, lo);
		bus_read(REG_SRAM_ADDR_HIGH, hi);
		bus_read(REG_SRAM_ADDR_UPPER, up);
		a = {up[2:0], hi, lo};
	endtask

	task automatic read_index(output index_count_t p);
		byte_t hi;
		byte_t lo;
		bus_read(REG_INDEX_HIGH, hi);   // Freezes low byte
		bus_read(REG_INDEX_LOW, lo);
		p = {hi, lo};
	endtask

	task automatic index_pulse();
		@(posedge CLK_MASTER);
		fd_index_in <= 1'b1;
		repeat (4) @(posedge CLK_MASTER);
		fd_index_in <= 1'b0;
	endtask

	task automatic wait_cycle(input int target);
		while (cycle_cnt < target) begin
			@(posedge CLK_MASTER);
		end
	endtask

	// Poll status until the write queue has drained
	task automatic wait_idle();
		byte_t s;
		int    polls;
		polls = 0;
		s     = 8'h01;
		while (s[STAT_BUSY] && (polls < 50)) begin
			bus_read(REG_STATUS, s);
			polls++;
		end
		if (s[STAT_BUSY]) begin
			$display("Write queue still busy after %0d status polls", polls);
			n_errors++;
		end
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_addr(input sram_addr_t got, input sram_addr_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_count(input index_count_t got, input index_count_t exp,
		input int tol, input string what);
		int diff;
		n_checks++;
		diff = int'(got) - int'(exp);
		if ((^got === 1'bx) || (diff > tol) || (diff < -tol)) begin
			$display("ERR %0t: %s got %0d expected %0d +-%0d", $time, what, got, exp, tol);
			n_errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (n_errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed, %0d errors", name, n_errors - errs_before);
		end
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic fill_steps();
		// kind, register, data, expected
		steps[0]  = {K_READ,      REG_MCO_TYPE_H,      8'h00, 8'hDD};
		steps[1]  = {K_READ,      REG_MCO_TYPE_L,      8'h00, 8'h55};
		steps[2]  = {K_READ,      REG_MCO_VER_H,       8'h00, 8'h00};
		steps[3]  = {K_READ,      REG_MCO_VER_L,       8'h00, 8'h1F};
		steps[4]  = {K_READ,      REG_FIXED_55,        8'h00, 8'h55};
		steps[5]  = {K_READ,      REG_FIXED_AA,        8'h00, 8'hAA};
		steps[6]  = {K_WRITE_RND, REG_SCRATCH,         8'h00, 8'h00};
		steps[7]  = {K_READ_RND,  REG_SCRATCH,         8'h00, 8'h00};
		steps[8]  = {K_READ_RND,  REG_SCRATCH_INV,     8'hFF, 8'h00};   // Inverted copy
		steps[9]  = {K_READ,      8'h20,               8'h00, 8'h00};   // Unmapped
		steps[10] = {K_WRITE,     REG_SRAM_ADDR_LOW,   8'hA5, 8'h00};
		steps[11] = {K_WRITE,     REG_SRAM_ADDR_HIGH,  8'h3C, 8'h00};
		steps[12] = {K_WRITE,     REG_SRAM_ADDR_UPPER, 8'hFF, 8'h00};
		steps[13] = {K_READ,      REG_SRAM_ADDR_LOW,   8'h00, 8'hA5};
		steps[14] = {K_READ,      REG_SRAM_ADDR_HIGH,  8'h00, 8'h3C};
		steps[15] = {K_READ,      REG_SRAM_ADDR_UPPER, 8'h00, 8'h07};   // Top 5 bits dropped
	endtask

	task automatic apply_steps(input int first, input int last);
		step_t s;
		byte_t got;
		for (int i = first; i <= last; i++) begin
			s = steps[i];
			case (s.kind)
				K_WRITE: bus_write(s.addr, s.data);
				K_READ: begin
					bus_read(s.addr, got);
					check_byte(got, s.exp, $sformatf("step %0d reg %h", i, s.addr));
				end
				K_WRITE_RND: begin
					draw_byte(rnd_q);
					bus_write(s.addr, rnd_q);
				end
				default: begin
					bus_read(s.addr, got);
					check_byte(got, rnd_q ^ s.data, $sformatf("step %0d reg %h", i, s.addr));
				end
			endcase
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		sram_addr_t   a;
		index_count_t p;
		byte_t        d;
		int           errs;
		int           t_rise;

		rst_n       = 1'b0;
		mcu_pmd_in  = '0;
		mcu_pmall   = 1'b0;
		mcu_pmrd    = 1'b0;
		mcu_pmwr    = 1'b0;
		fd_index_in = 1'b0;
		fill_steps();
		repeat (16) @(posedge CLK_MASTER);
		rst_n <= 1'b1;

		errs = n_errors;
		apply_steps(0, 9);
		end_test("identity and scratchpad", errs);

		errs = n_errors;
		apply_steps(10, 15);
		read_sram_addr(a);
		check_addr(a, 19'h73CA5, "loaded address");
		end_test("address load", errs);

		errs = n_errors;
		load_sram_addr(WR_START);
		for (int i = 0; i < 8; i++) begin
			draw_byte(wr_bytes[i]);
			bus_write(REG_SRAM_DATA, wr_bytes[i]);
		end
		wait_idle();
		for (int i = 0; i < 8; i++) begin
			check_byte(sram_mem[(WR_START + i) & 19'h1FF], wr_bytes[i], "SRAM model byte");
		end
		read_sram_addr(a);
		check_addr(a, WR_START + 19'd8, "address after writes");
		bus_read(REG_STATUS, d);
		check_byte(d, 8'h00, "status after drain");
		end_test("SRAM write path", errs);

		errs = n_errors;
		load_sram_addr(WR_START);
		for (int i = 0; i < 8; i++) begin
			bus_read(REG_SRAM_DATA, d);
			check_byte(d, wr_bytes[i], "SRAM read-back");
			read_sram_addr(a);
			check_addr(a, WR_START + 19'(i + 1), "address after read");
		end
		end_test("SRAM read-back", errs);

		// Rising edges 5 and 12 ticks apart
		errs = n_errors;
		index_pulse();
		t_rise = cycle_cnt;
		wait_cycle(t_rise + 5 * TICK_10US_DIV);
		index_pulse();
		t_rise = cycle_cnt;
		read_index(p);
		check_count(p, 16'd5, 1, "index period 5");
		wait_cycle(t_rise + 12 * TICK_10US_DIV);
		index_pulse();
		read_index(p);
		check_count(p, 16'd12, 1, "index period 12");
		end_test("index period", errs);

		// Queue gains a byte every 20 cycles until full
		errs = n_errors;
		@(posedge CLK_MASTER);
		mcu_pmd_in <= REG_SRAM_DATA;
		mcu_pmall  <= 1'b1;
		@(posedge CLK_MASTER);
		mcu_pmall <= 1'b0;
		for (int i = 0; i < OVF_BYTES; i++) begin
			draw_byte(d);
			mcu_pmd_in <= d;
			mcu_pmwr   <= 1'b1;
			repeat (2) @(posedge CLK_MASTER);
			mcu_pmwr <= 1'b0;
			repeat (2) @(posedge CLK_MASTER);
		end
		bus_read(REG_STATUS, d);
		check_byte(d & 8'h02, 8'h02, "overflow bit after burst");
		bus_write(REG_STATUS, 8'h00);
		wait_idle();
		bus_read(REG_STATUS, d);
		check_byte(d, 8'h00, "status after clear");
		end_test("overflow", errs);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
